// File: hw/classifier_spectrum_pkg.sv
package classifier_spectrum_pkg;

  // one magnitude per spectrum bin, unsigned
  localparam int MAG_W = 32;

  typedef logic [MAG_W-1:0] mag_t;  // bin magnitude and threshold

  // bin index used for the band cutoffs
  localparam int BIN_IDX_W = 8;

  typedef logic [BIN_IDX_W-1:0] bin_idx_t;

  // bins per frame unless the top level overrides it
  localparam int DEFAULT_N_BINS = 32;

  // largest bin count the cutoff index can still address
  localparam int MAX_N_BINS = 1 << BIN_IDX_W;

endpackage : classifier_spectrum_pkg

// File: hw/classifier_gate_pkg.sv
package classifier_gate_pkg;

  // counts frames, not clock cycles
  typedef logic [15:0] frame_cnt_t;

  // hysteresis states of the presence gate
  typedef enum logic [1:0] {
    GATE_QUIET = 2'd0,  // no sound reported
    GATE_SOUND = 2'd1,  // sound reported, watching for a quiet run
    GATE_HOLD  = 2'd2   // quiet run seen, output still held high
  } gate_state_e;

endpackage : classifier_gate_pkg

// File: hw/band_config_regs.sv
module band_config_regs
  import classifier_spectrum_pkg::*;
#(
  parameter int N_BINS = DEFAULT_N_BINS
) (
  input  logic              clk,
  input  logic              reset,

  input  logic              cutoff_low_val,
  input  bin_idx_t          cutoff_low_msg,
  input  logic              cutoff_high_val,
  input  bin_idx_t          cutoff_high_msg,
  input  logic              cutoff_mag_val,
  input  mag_t              cutoff_mag_msg,

  output logic [N_BINS-1:0] band_mask,
  output mag_t              threshold
);

  bin_idx_t          cutoff_low;
  bin_idx_t          cutoff_high;
  logic [N_BINS-1:0] mask_next;

  always_ff @(posedge clk) begin
    if (reset) begin
      cutoff_low  <= '0;
      cutoff_high <= '0;
      threshold   <= '0;
    end else begin
      if (cutoff_low_val)  cutoff_low  <= cutoff_low_msg;
      if (cutoff_high_val) cutoff_high <= cutoff_high_msg;
      if (cutoff_mag_val)  threshold   <= cutoff_mag_msg;
    end
  end

  // bit i set when low <= i <= high, an inverted range leaves it empty
  always_comb begin
    for (int i = 0; i < N_BINS; i++) begin
      mask_next[i] = (int'(cutoff_low) <= i) && (i <= int'(cutoff_high));
    end
  end

  // registered so the detector sees a plain mask one edge after the cutoffs
  always_ff @(posedge clk) begin
    if (reset) begin
      band_mask <= N_BINS'(1);  // low = high = 0 selects bin 0
    end else begin
      band_mask <= mask_next;
    end
  end

endmodule : band_config_regs

// File: hw/band_peak_detector.sv
module band_peak_detector
  import classifier_spectrum_pkg::*;
#(
  parameter int N_BINS = DEFAULT_N_BINS
) (
  input  logic              clk,
  input  logic              reset,

  // frame from the spectrum unit
  input  logic              recv_val,
  input  mag_t              recv_msg [N_BINS],

  // decoded configuration
  input  logic [N_BINS-1:0] band_mask,
  input  mag_t              threshold,

  // per frame hot decision
  output logic              frame_done,
  output logic              frame_hot
);

  mag_t frame_mag [N_BINS];  // latched frame
  logic frame_val;           // frame_mag holds a fresh frame this cycle
  mag_t peak;                // largest in-band magnitude
  logic peak_over;

  // frame payload, captured only on the strobe
  always_ff @(posedge clk) begin
    if (recv_val) begin
      for (int i = 0; i < N_BINS; i++) begin
        frame_mag[i] <= recv_msg[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      frame_val <= 1'b0;
    end else begin
      frame_val <= recv_val;
    end
  end

  // masked-out bins count as zero, so they can never win
  always_comb begin
    peak = '0;
    for (int i = 0; i < N_BINS; i++) begin
      if (band_mask[i] && (frame_mag[i] > peak)) begin
        peak = frame_mag[i];
      end
    end
  end

  // strictly above, equal to the threshold is still quiet
  assign peak_over = peak > threshold;

  always_ff @(posedge clk) begin
    if (reset) begin
      frame_done <= 1'b0;
      frame_hot  <= 1'b0;
    end else begin
      frame_done <= frame_val;
      frame_hot  <= frame_val && peak_over;  // low between frames
    end
  end

endmodule : band_peak_detector

// File: hw/sound_gate.sv
module sound_gate
  import classifier_gate_pkg::*;
#(
  parameter frame_cnt_t ON_FRAMES   = 16'd300,
  parameter frame_cnt_t OFF_FRAMES  = 16'd2000,
  parameter frame_cnt_t HOLD_FRAMES = 16'd10
) (
  input  logic clk,
  input  logic reset,

  input  logic frame_done,
  input  logic frame_hot,

  output logic send_val,
  output logic send_msg
);

  gate_state_e state, state_next;
  frame_cnt_t  on_cnt, on_cnt_next;
  frame_cnt_t  off_cnt, off_cnt_next;
  frame_cnt_t  hold_cnt, hold_cnt_next;
  frame_cnt_t  on_inc, off_inc, hold_inc;

  assign on_inc   = on_cnt + 16'd1;
  assign off_inc  = off_cnt + 16'd1;
  assign hold_inc = hold_cnt + 16'd1;

  // next state, evaluated only when a frame decision arrives
  always_comb begin
    state_next    = state;
    on_cnt_next   = on_cnt;
    off_cnt_next  = off_cnt;
    hold_cnt_next = hold_cnt;

    if (frame_done) begin
      case (state)
        GATE_QUIET: begin
          if (!frame_hot) begin
            on_cnt_next = '0;  // run broken
          end else if (on_inc == ON_FRAMES) begin
            state_next  = GATE_SOUND;
            on_cnt_next = '0;
          end else begin
            on_cnt_next = on_inc;
          end
        end

        GATE_SOUND: begin
          if (frame_hot) begin
            off_cnt_next = '0;
          end else if (off_inc == OFF_FRAMES) begin
            state_next    = GATE_HOLD;
            off_cnt_next  = '0;
            hold_cnt_next = '0;
          end else begin
            off_cnt_next = off_inc;
          end
        end

        GATE_HOLD: begin
          if (frame_hot) begin
            state_next    = GATE_SOUND;  // sound came back during hold
            hold_cnt_next = '0;
          end else if (hold_inc == HOLD_FRAMES) begin
            state_next    = GATE_QUIET;
            hold_cnt_next = '0;
          end else begin
            hold_cnt_next = hold_inc;
          end
        end

        default: begin
          state_next    = GATE_QUIET;
          on_cnt_next   = '0;
          off_cnt_next  = '0;
          hold_cnt_next = '0;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= GATE_QUIET;
      on_cnt   <= '0;
      off_cnt  <= '0;
      hold_cnt <= '0;
      send_val <= 1'b0;
      send_msg <= 1'b0;
    end else begin
      state    <= state_next;
      on_cnt   <= on_cnt_next;
      off_cnt  <= off_cnt_next;
      hold_cnt <= hold_cnt_next;
      send_val <= frame_done;                 // one verdict per frame
      send_msg <= state_next != GATE_QUIET;   // sound or hold reads as present
    end
  end

endmodule : sound_gate

// File: hw/sound_classifier.sv
module sound_classifier
  import classifier_spectrum_pkg::*;
  import classifier_gate_pkg::*;
#(
  parameter int         N_BINS      = DEFAULT_N_BINS,
  parameter frame_cnt_t ON_FRAMES   = 16'd300,
  parameter frame_cnt_t OFF_FRAMES  = 16'd2000,
  parameter frame_cnt_t HOLD_FRAMES = 16'd10
) (
  input  logic     clk,
  input  logic     reset,

  // spectrum frame
  input  logic     recv_val,
  input  mag_t     recv_msg [N_BINS],

  // band and threshold setup
  input  logic     cutoff_low_val,
  input  bin_idx_t cutoff_low_msg,
  input  logic     cutoff_high_val,
  input  bin_idx_t cutoff_high_msg,
  input  logic     cutoff_mag_val,
  input  mag_t     cutoff_mag_msg,

  // per frame verdict, no back-pressure
  output logic     send_val,
  output logic     send_msg
);

  logic [N_BINS-1:0] band_mask;
  mag_t              threshold;
  logic              frame_done;
  logic              frame_hot;

  band_config_regs #(
    .N_BINS (N_BINS)
  ) u_config (
    .clk             (clk),
    .reset           (reset),
    .cutoff_low_val  (cutoff_low_val),
    .cutoff_low_msg  (cutoff_low_msg),
    .cutoff_high_val (cutoff_high_val),
    .cutoff_high_msg (cutoff_high_msg),
    .cutoff_mag_val  (cutoff_mag_val),
    .cutoff_mag_msg  (cutoff_mag_msg),
    .band_mask       (band_mask),
    .threshold       (threshold)
  );

  // frame latched at k, hot decision at k+1
  band_peak_detector #(
    .N_BINS (N_BINS)
  ) u_detector (
    .clk        (clk),
    .reset      (reset),
    .recv_val   (recv_val),
    .recv_msg   (recv_msg),
    .band_mask  (band_mask),
    .threshold  (threshold),
    .frame_done (frame_done),
    .frame_hot  (frame_hot)
  );

  // verdict at k+2
  sound_gate #(
    .ON_FRAMES   (ON_FRAMES),
    .OFF_FRAMES  (OFF_FRAMES),
    .HOLD_FRAMES (HOLD_FRAMES)
  ) u_gate (
    .clk        (clk),
    .reset      (reset),
    .frame_done (frame_done),
    .frame_hot  (frame_hot),
    .send_val   (send_val),
    .send_msg   (send_msg)
  );

endmodule : sound_classifier

// File: dv/tb_sound_classifier.sv
module tb_sound_classifier
  import classifier_spectrum_pkg::*;
  import classifier_gate_pkg::*;
();

  localparam int         N_BINS      = 8;
  localparam frame_cnt_t ON_FRAMES   = 16'd3;
  localparam frame_cnt_t OFF_FRAMES  = 16'd4;
  localparam frame_cnt_t HOLD_FRAMES = 16'd2;
  localparam int         DLY         = 5;   // drive delay after the rising edge
  localparam int         DRAIN_LIMIT = 50;  // cycles to wait for pending verdicts

  logic     clk = 1'b0;
  logic     reset;
  logic     recv_val;
  mag_t     recv_msg [N_BINS];
  logic     cutoff_low_val, cutoff_high_val, cutoff_mag_val;
  bin_idx_t cutoff_low_msg, cutoff_high_msg;
  mag_t     cutoff_mag_msg;
  logic     send_val, send_msg;

  // reference model
  bin_idx_t    m_low, m_high;
  mag_t        m_thr;
  gate_state_e m_state;
  int          on_cnt, off_cnt, hold_cnt;
  logic        exp_verdict_q [$];
  int          exp_cycle_q [$];  // cycle in which each verdict is due

  mag_t   frame_buf [N_BINS];
  int     cycle = 0;
  int     err_count = 0;
  int     fail_count = 0;
  int     verdicts_seen = 0;
  logic   last_verdict;
  integer seed = 32'h733b;

  sound_classifier #(
    .N_BINS      (N_BINS),
    .ON_FRAMES   (ON_FRAMES),
    .OFF_FRAMES  (OFF_FRAMES),
    .HOLD_FRAMES (HOLD_FRAMES)
  ) u_dut (
    .clk             (clk),
    .reset           (reset),
    .recv_val        (recv_val),
    .recv_msg        (recv_msg),
    .cutoff_low_val  (cutoff_low_val),
    .cutoff_low_msg  (cutoff_low_msg),
    .cutoff_high_val (cutoff_high_val),
    .cutoff_high_msg (cutoff_high_msg),
    .cutoff_mag_val  (cutoff_mag_val),
    .cutoff_mag_msg  (cutoff_mag_msg),
    .send_val        (send_val),
    .send_msg        (send_msg)
  );

  always #50 clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  task automatic check_verdict(input logic exp, input logic got);
    if (got !== exp) begin
      $display("ERR %0t: verdict %0b, expected %0b", $time, got, exp);
      err_count++;
    end
  endtask

  task automatic check_peak_hot(input logic exp, input logic got);
    if (got !== exp) begin
      $display("ERR %0t: hot decision %0b, expected %0b", $time, got, exp);
      err_count++;
    end
  endtask

  task automatic check_latency(input int exp, input int got);
    if (got != exp) begin
      $display("ERR %0t: verdict in cycle %0d, expected cycle %0d", $time, got, exp);
      err_count++;
    end
  endtask

  // sampled on the falling edge, away from the DUT update
  always @(negedge clk) begin
    if (send_val) begin
      verdicts_seen++;
      last_verdict = send_msg;
      if (exp_verdict_q.size() == 0) begin
        $display("verdict at time %0t arrived with no frame pending", $time);
        fail_count++;
      end else begin
        check_verdict(exp_verdict_q.pop_front(), send_msg);
        check_latency(exp_cycle_q.pop_front(), cycle);
      end
    end
  end

  // band rule then gate rule, one call per frame
  task automatic model_frame();
    mag_t peak;
    logic hot;
    peak = '0;
    for (int i = 0; i < N_BINS; i++) begin
      if (i >= int'(m_low) && i <= int'(m_high) && frame_buf[i] > peak) peak = frame_buf[i];
    end
    hot = peak > m_thr;  // equal is quiet
    case (m_state)
      GATE_QUIET: begin
        on_cnt = hot ? on_cnt + 1 : 0;
        if (on_cnt == int'(ON_FRAMES)) begin
          m_state = GATE_SOUND;
          on_cnt  = 0;
        end
      end
      GATE_SOUND: begin
        off_cnt = hot ? 0 : off_cnt + 1;
        if (off_cnt == int'(OFF_FRAMES)) begin
          m_state  = GATE_HOLD;
          off_cnt  = 0;
          hold_cnt = 0;
        end
      end
      default: begin
        hold_cnt = hot ? 0 : hold_cnt + 1;
        if (hot) begin
          m_state = GATE_SOUND;
        end else if (hold_cnt == int'(HOLD_FRAMES)) begin
          m_state  = GATE_QUIET;
          hold_cnt = 0;
        end
      end
    endcase
    exp_verdict_q.push_back(m_state != GATE_QUIET);
    exp_cycle_q.push_back(cycle + 3);  // latched next edge, verdict two edges later
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #DLY;
    end
  endtask

  task automatic send_frame();
    recv_val = 1'b1;
    for (int i = 0; i < N_BINS; i++) recv_msg[i] = frame_buf[i];
    model_frame();
    @(posedge clk);
    #DLY;
    recv_val = 1'b0;
  endtask

  // new cutoffs, plus one spare cycle so the next frame sees the new mask
  task automatic set_config(input bin_idx_t low, input bin_idx_t high, input mag_t thr);
    cutoff_low_val  = 1'b1;
    cutoff_high_val = 1'b1;
    cutoff_mag_val  = 1'b1;
    cutoff_low_msg  = low;
    cutoff_high_msg = high;
    cutoff_mag_msg  = thr;
    m_low  = low;
    m_high = high;
    m_thr  = thr;
    @(posedge clk);
    #DLY;
    cutoff_low_val  = 1'b0;
    cutoff_high_val = 1'b0;
    cutoff_mag_val  = 1'b0;
    idle(1);
  endtask

  task automatic one_bin(input int bin, input mag_t val);
    for (int i = 0; i < N_BINS; i++) frame_buf[i] = '0;
    frame_buf[bin] = val;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_verdict_q.size() != 0 && waited < DRAIN_LIMIT) begin
      @(posedge clk);
      #DLY;
      waited++;
    end
    if (exp_verdict_q.size() != 0) begin
      $display("timeout: %0d verdicts never arrived by time %0t", exp_verdict_q.size(), $time);
      fail_count++;
      exp_verdict_q.delete();
      exp_cycle_q.delete();
    end
  endtask

  // all-zero frames are quiet under any config
  task automatic settle_quiet();
    int n;
    n = 0;
    one_bin(0, '0);
    do begin
      send_frame();
      n++;
    end while (m_state != GATE_QUIET && n < 16);
    wait_drain();
  endtask

  // a run of ON_FRAMES equal frames turns sound on only if the frame is hot
  task automatic band_case(input logic exp_hot);
    repeat (int'(ON_FRAMES)) send_frame();
    wait_drain();
    check_peak_hot(exp_hot, last_verdict);
    settle_quiet();
  endtask

  task automatic test_reset();
    idle(10);  // monitor flags any strobe here
    one_bin(0, '0);
    send_frame();
    wait_drain();
    check_verdict(1'b0, last_verdict);
  endtask

  task automatic test_band();
    set_config(8'd2, 8'd5, 32'd1000);
    one_bin(0, 32'd5000);
    frame_buf[7] = 32'd5000;
    band_case(1'b0);
    one_bin(3, 32'd1001);
    band_case(1'b1);
    one_bin(5, 32'd1001);
    band_case(1'b1);
    one_bin(4, 32'd1000);
    band_case(1'b0);
    set_config(8'd5, 8'd2, 32'd1000);  // inverted
    one_bin(3, 32'd5000);
    band_case(1'b0);
  endtask

  task automatic test_turn_on();
    set_config(8'd0, 8'd7, 32'd100);
    one_bin(6, 32'd500);
    repeat (2) send_frame();
    one_bin(6, 32'd50);
    send_frame();
    wait_drain();
    check_verdict(1'b0, last_verdict);
    one_bin(6, 32'd500);
    repeat (3) send_frame();
    wait_drain();
    check_verdict(1'b1, last_verdict);
  endtask

  task automatic test_turn_off();
    one_bin(6, 32'd50);
    repeat (5) send_frame();
    wait_drain();
    check_verdict(1'b1, last_verdict);
    send_frame();
    wait_drain();
    check_verdict(1'b0, last_verdict);
    one_bin(6, 32'd500);
    repeat (3) send_frame();
    one_bin(6, 32'd50);
    repeat (4) send_frame();  // now holding
    one_bin(6, 32'd500);
    send_frame();
    one_bin(6, 32'd50);
    repeat (4) send_frame();  // full off run again, still high
    wait_drain();
    check_verdict(1'b1, last_verdict);
    settle_quiet();
  endtask

  task automatic test_random();
    int sent;
    int len;
    int base;
    sent = 0;
    base = verdicts_seen;
    set_config(8'd1, 8'd6, 32'd3500);
    while (sent < 200) begin
      len = 1 + {$random(seed)} % 8;
      if (len > 200 - sent) len = 200 - sent;
      repeat (len) begin
        for (int i = 0; i < N_BINS; i++) frame_buf[i] = mag_t'({$random(seed)} % 4096);
        send_frame();
      end
      sent += len;
      if ({$random(seed)} % 4 == 0) begin
        set_config(bin_idx_t'({$random(seed)} % 8), bin_idx_t'({$random(seed)} % 8),
                   mag_t'({$random(seed)} % 4096));
      end else begin
        idle(2);
      end
    end
    wait_drain();
    if (verdicts_seen - base != sent) begin
      $display("got %0d verdicts for %0d random frames", verdicts_seen - base, sent);
      fail_count++;
    end
  endtask

  initial begin
    reset           = 1'b1;
    recv_val        = 1'b0;
    cutoff_low_val  = 1'b0;
    cutoff_high_val = 1'b0;
    cutoff_mag_val  = 1'b0;
    cutoff_low_msg  = '0;
    cutoff_high_msg = '0;
    cutoff_mag_msg  = '0;
    for (int i = 0; i < N_BINS; i++) recv_msg[i] = '0;
    m_low    = '0;
    m_high   = '0;
    m_thr    = '0;
    m_state  = GATE_QUIET;
    on_cnt   = 0;
    off_cnt  = 0;
    hold_cnt = 0;
    repeat (8) @(posedge clk);
    #DLY;
    reset = 1'b0;
    test_reset();
    test_band();
    test_turn_on();
    test_turn_off();
    test_random();
    $display("value errors %0d, other failures %0d", err_count, fail_count);
    if (err_count == 0 && fail_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // overall guard against a stuck run
  initial begin
    repeat (20000) @(posedge clk);
    $display("simulation ran past its cycle limit and was stopped");
    $display("ERRORS FOUND");
    $finish;
  end

endmodule : tb_sound_classifier

// File: tb.f
hw/classifier_spectrum_pkg.sv
hw/classifier_gate_pkg.sv
hw/band_config_regs.sv
hw/band_peak_detector.sv
hw/sound_gate.sv
hw/sound_classifier.sv
dv/tb_sound_classifier.sv

// File: Makefile
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        ?= tb_sound_classifier
LINT_TOP   ?= sound_classifier
FILELIST   ?= tb.f
OBJ_DIR    ?= obj_dir
PASS_MSG   := NO ERRORS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
